// File: five_stage_cpu.f
logic/cpu_pkg.sv
logic/stage_register.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/five_stage_cpu.sv
sim/five_stage_cpu_assertions.sv
sim/five_stage_cpu_tb.sv

// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int data_words = 64;
    localparam int data_index_width = $clog2(data_words);

    // major opcodes
    localparam logic [6:0] op_reg_arith = 7'b0110011;
    localparam logic [6:0] op_imm_arith = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_jal = 7'b1101111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_word = 3'b010; // lw / sw width

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b // lui and jal
    } alu_op_t;

    // decode -> execute
    typedef struct packed {
        logic [xlen-1:0] operand_a;
        logic [xlen-1:0] operand_b;
        logic [xlen-1:0] store_data;
        alu_op_t alu_op;
        logic load;
        logic store;
        logic write;
        logic [reg_addr_width-1:0] rd;
    } decoded_t;

    // execute -> memory
    typedef struct packed {
        logic [xlen-1:0] result; // also the data address
        logic [xlen-1:0] store_data;
        logic load;
        logic store;
        logic write;
        logic [reg_addr_width-1:0] rd;
    } executed_t;

    // memory -> writeback
    typedef struct packed {
        logic [xlen-1:0] result;
        logic write;
        logic [reg_addr_width-1:0] rd;
    } retired_t;

endpackage

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
    input  logic [xlen-1:0] fetch_pc,
    input  logic [xlen-1:0] fetch_instr,
    input  logic fetch_valid,
    output logic [reg_addr_width-1:0] read_addr_1,
    output logic [reg_addr_width-1:0] read_addr_2,
    input  logic [xlen-1:0] read_data_1,
    input  logic [xlen-1:0] read_data_2,
    input  logic [reg_addr_width-1:0] ex_rd,
    input  logic ex_write,
    input  logic [reg_addr_width-1:0] mem_rd,
    input  logic mem_write,
    input  logic [reg_addr_width-1:0] wb_rd,
    input  logic wb_write,
    output logic hazard_stall,
    output logic jump_taken,
    output logic [xlen-1:0] jump_target,
    output decoded_t decoded,
    output logic decoded_valid
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [reg_addr_width-1:0] rd;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic uses_rs1;
    logic uses_rs2;
    logic legal;
    logic is_jal;
    logic rs1_busy;
    logic rs2_busy;

    assign opcode = fetch_instr[6:0];
    assign rd = fetch_instr[11:7];
    assign funct3 = fetch_instr[14:12];
    assign funct7 = fetch_instr[31:25];
    assign read_addr_1 = fetch_instr[19:15];
    assign read_addr_2 = fetch_instr[24:20];

    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
    assign imm_s = {{20{fetch_instr[31]}}, fetch_instr[31:25], fetch_instr[11:7]};
    assign imm_u = {fetch_instr[31:12], 12'b0};
    assign imm_j = {{12{fetch_instr[31]}}, fetch_instr[19:12], fetch_instr[20],
                    fetch_instr[30:21], 1'b0};

    always_comb begin
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        legal = 1'b1;
        is_jal = 1'b0;
        decoded.operand_a = read_data_1;
        decoded.operand_b = read_data_2;
        decoded.store_data = read_data_2;
        decoded.alu_op = alu_add;
        decoded.load = 1'b0;
        decoded.store = 1'b0;
        decoded.write = 1'b0;
        decoded.rd = rd;
        case (opcode)
            op_reg_arith, op_imm_arith: begin
                uses_rs1 = 1'b1;
                uses_rs2 = (opcode == op_reg_arith);
                decoded.write = 1'b1;
                if (opcode == op_imm_arith) decoded.operand_b = imm_i;
                case (funct3)
                    f3_add_sub: begin
                        // only the register form has sub
                        if (opcode == op_reg_arith && funct7[5]) decoded.alu_op = alu_sub;
                    end
                    f3_slt: decoded.alu_op = alu_slt;
                    f3_xor: decoded.alu_op = alu_xor;
                    f3_or: decoded.alu_op = alu_or;
                    f3_and: decoded.alu_op = alu_and;
                    default: legal = 1'b0; // shifts, sltu
                endcase
            end
            op_load: begin
                uses_rs1 = 1'b1;
                decoded.operand_b = imm_i;
                decoded.load = 1'b1;
                decoded.write = 1'b1;
                legal = (funct3 == f3_word);
            end
            op_store: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                decoded.operand_b = imm_s;
                decoded.store = 1'b1;
                legal = (funct3 == f3_word);
            end
            op_lui: begin
                decoded.operand_b = imm_u;
                decoded.alu_op = alu_pass_b;
                decoded.write = 1'b1;
            end
            op_jal: begin
                is_jal = 1'b1;
                decoded.operand_b = fetch_pc + xlen'(4); // link value
                decoded.alu_op = alu_pass_b;
                decoded.write = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        if (rd == '0) decoded.write = 1'b0; // x0 target writes nothing
    end

    // the regfile has no write-through so pending writes in ex, mem and wb all count
    always_comb begin
        rs1_busy = read_addr_1 != '0 && ((ex_write && ex_rd == read_addr_1)
                   || (mem_write && mem_rd == read_addr_1)
                   || (wb_write && wb_rd == read_addr_1));
        rs2_busy = read_addr_2 != '0 && ((ex_write && ex_rd == read_addr_2)
                   || (mem_write && mem_rd == read_addr_2)
                   || (wb_write && wb_rd == read_addr_2));
    end

    assign hazard_stall = fetch_valid && ((uses_rs1 && rs1_busy) || (uses_rs2 && rs2_busy));
    assign jump_taken = fetch_valid && legal && is_jal; // jal reads no source register
    assign jump_target = fetch_pc + imm_j;
    assign decoded_valid = fetch_valid && legal;

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
    input  decoded_t decoded,
    output executed_t executed
);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] result;

    assign a = decoded.operand_a;
    assign b = decoded.operand_b;

    // lw/sw decode as add with the offset in b
    always_comb begin
        case (decoded.alu_op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or: result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_pass_b: result = b;
            default: result = '0;
        endcase
    end

    always_comb begin
        executed.result = result;
        executed.store_data = decoded.store_data;
        executed.load = decoded.load;
        executed.store = decoded.store;
        executed.write = decoded.write;
        executed.rd = decoded.rd;
    end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic hazard_stall,
    input  logic jump_taken,
    input  logic [xlen-1:0] jump_target,
    output logic [xlen-1:0] instr_addr,
    input  logic [xlen-1:0] instr_data,
    output logic [xlen-1:0] fetch_pc,
    output logic [xlen-1:0] fetch_instr,
    output logic fetch_valid
);
    logic [xlen-1:0] pc; // queued program counter

    assign instr_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
            fetch_valid <= 1'b0;
        end else if (jump_taken) begin
            // drop the word fetched behind the jal
            pc <= jump_target;
            fetch_valid <= 1'b0;
        end else if (!hazard_stall) begin
            pc <= pc + xlen'(4);
            fetch_valid <= 1'b1;
        end
    end

    // fetch register payload
    always_ff @(posedge clk) begin
        if (!hazard_stall && !jump_taken) begin
            fetch_pc <= pc;
            fetch_instr <= instr_data;
        end
    end

endmodule

// File: logic/five_stage_cpu.sv
`timescale 1ns/10ps

module five_stage_cpu import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic [xlen-1:0] instr_addr,
    input  logic [xlen-1:0] instr_data,
    output logic retire_valid,
    output logic [reg_addr_width-1:0] retire_rd,
    output logic [xlen-1:0] retire_data
);
    logic [xlen-1:0] fetch_pc;
    logic [xlen-1:0] fetch_instr;
    logic fetch_valid;

    logic hazard_stall;
    logic jump_taken;
    logic [xlen-1:0] jump_target;

    logic [reg_addr_width-1:0] read_addr_1;
    logic [reg_addr_width-1:0] read_addr_2;
    logic [xlen-1:0] read_data_1;
    logic [xlen-1:0] read_data_2;

    decoded_t decoded;
    logic decoded_valid;
    decoded_t ex_payload;
    logic ex_valid;
    executed_t executed;
    executed_t mem_payload;
    logic mem_valid;
    retired_t retired;
    retired_t wb_payload;
    logic wb_valid;

    // register writes still in flight
    logic ex_write;
    logic mem_write;
    logic wb_write;

    assign ex_write = ex_valid && ex_payload.write;
    assign mem_write = mem_valid && mem_payload.write;
    assign wb_write = wb_valid && wb_payload.write;

    assign retire_valid = wb_write;
    assign retire_rd = wb_payload.rd;
    assign retire_data = wb_payload.result;

    fetch_stage fetch_stage (
        .clk ( clk ),
        .rst ( rst ),
        .hazard_stall ( hazard_stall ),
        .jump_taken ( jump_taken ),
        .jump_target ( jump_target ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .fetch_pc ( fetch_pc ),
        .fetch_instr ( fetch_instr ),
        .fetch_valid ( fetch_valid )
    );

    decode_stage decode_stage (
        .fetch_pc ( fetch_pc ),
        .fetch_instr ( fetch_instr ),
        .fetch_valid ( fetch_valid ),
        .read_addr_1 ( read_addr_1 ),
        .read_addr_2 ( read_addr_2 ),
        .read_data_1 ( read_data_1 ),
        .read_data_2 ( read_data_2 ),
        .ex_rd ( ex_payload.rd ),
        .ex_write ( ex_write ),
        .mem_rd ( mem_payload.rd ),
        .mem_write ( mem_write ),
        .wb_rd ( wb_payload.rd ),
        .wb_write ( wb_write ),
        .hazard_stall ( hazard_stall ),
        .jump_taken ( jump_taken ),
        .jump_target ( jump_target ),
        .decoded ( decoded ),
        .decoded_valid ( decoded_valid )
    );

    register_file register_file (
        .clk ( clk ),
        .rst ( rst ),
        .read_addr_1 ( read_addr_1 ),
        .read_addr_2 ( read_addr_2 ),
        .read_data_1 ( read_data_1 ),
        .read_data_2 ( read_data_2 ),
        .write_addr ( wb_payload.rd ),
        .write_data ( wb_payload.result ),
        .write_enable ( wb_write )
    );

    // a stall turns the decode -> execute slot into a bubble
    stage_register #(.payload_t(decoded_t)) execute_register (
        .clk ( clk ),
        .rst ( rst ),
        .hold ( 1'b0 ),
        .bubble ( hazard_stall ),
        .valid_in ( decoded_valid ),
        .payload_in ( decoded ),
        .valid_out ( ex_valid ),
        .payload_out ( ex_payload )
    );

    execute_stage execute_stage (
        .decoded ( ex_payload ),
        .executed ( executed )
    );

    stage_register #(.payload_t(executed_t)) memory_register (
        .clk ( clk ),
        .rst ( rst ),
        .hold ( 1'b0 ),
        .bubble ( 1'b0 ),
        .valid_in ( ex_valid ),
        .payload_in ( executed ),
        .valid_out ( mem_valid ),
        .payload_out ( mem_payload )
    );

    memory_stage memory_stage (
        .clk ( clk ),
        .executed ( mem_payload ),
        .executed_valid ( mem_valid ),
        .retired ( retired )
    );

    stage_register #(.payload_t(retired_t)) writeback_register (
        .clk ( clk ),
        .rst ( rst ),
        .hold ( 1'b0 ),
        .bubble ( 1'b0 ),
        .valid_in ( mem_valid ),
        .payload_in ( retired ),
        .valid_out ( wb_valid ),
        .payload_out ( wb_payload )
    );

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/10ps

module memory_stage import cpu_pkg::*; (
    input  logic clk,
    input  executed_t executed,
    input  logic executed_valid,
    output retired_t retired
);
    logic [xlen-1:0] ram [data_words];
    logic [data_index_width-1:0] word_index;

    assign word_index = executed.result[data_index_width+1:2]; // word address with upper bits ignored

    always_ff @(posedge clk) begin
        if (executed_valid && executed.store) begin
            ram[word_index] <= executed.store_data;
        end
    end

    always_comb begin
        retired.result = executed.load ? ram[word_index] : executed.result;
        retired.write = executed.write;
        retired.rd = executed.rd;
    end

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file import cpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic [reg_addr_width-1:0] read_addr_1,
    input  logic [reg_addr_width-1:0] read_addr_2,
    output logic [xlen-1:0] read_data_1,
    output logic [xlen-1:0] read_data_2,
    input  logic [reg_addr_width-1:0] write_addr,
    input  logic [xlen-1:0] write_data,
    input  logic write_enable
);
    logic [xlen-1:0] regs [1:(2**reg_addr_width)-1]; // no storage for x0

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // no bypass so a write shows up the cycle after its edge
    assign read_data_1 = (read_addr_1 == '0) ? '0 : regs[read_addr_1];
    assign read_data_2 = (read_addr_2 == '0) ? '0 : regs[read_addr_2];

endmodule

// File: logic/stage_register.sv
`timescale 1ns/10ps

module stage_register #(
    parameter type payload_t = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic hold,
    input  logic bubble,
    input  logic valid_in,
    input  payload_t payload_in,
    output logic valid_out,
    output payload_t payload_out
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_out <= 1'b0;
        end else if (!hold) begin
            valid_out <= valid_in && !bubble; // bubble inserts an empty slot
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            payload_out <= payload_in;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/bash
# build and run the five stage cpu testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module five_stage_cpu_tb -f five_stage_cpu.f \
    && ./obj_dir/Vfive_stage_cpu_tb > sim.log 2>&1 \
    || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && exit 1 || exit 0

// File: sim/five_stage_cpu_assertions.sv
`timescale 1ns/10ps

module five_stage_cpu_assertions import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [xlen-1:0] instr_addr,
    input logic retire_valid,
    input logic [reg_addr_width-1:0] retire_rd,
    input logic jump_taken,
    input logic hazard_stall
);

    int failures = 0; // assertions that did not hold so far

    no_x0_retire: assert property (@(posedge clk) disable iff (!rst)
        retire_valid |-> retire_rd != '0)
        else begin
            $error("x0 write reached writeback");
            failures++;
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst)
        instr_addr[1:0] == 2'b00)
        else begin
            $error("instr_addr not word aligned");
            failures++;
        end

    jump_not_stalled: assert property (@(posedge clk) disable iff (!rst)
        !(jump_taken && hazard_stall))
        else begin
            $error("jump taken during a hazard stall");
            failures++;
        end

    // writeback register is empty right after a reset edge
    quiet_after_reset: assert property (@(posedge clk) !rst |=> !retire_valid)
        else begin
            $error("retire_valid high in the cycle after reset");
            failures++;
        end

endmodule

bind five_stage_cpu five_stage_cpu_assertions assertions (.*);

// File: sim/five_stage_cpu_tb.sv
`timescale 1ns/10ps

module five_stage_cpu_tb import cpu_pkg::*; ();

    localparam int max_words = 256;

    logic clk = 1'b0;
    logic rst = 1'b0;
    logic [xlen-1:0] instr_addr;
    logic [xlen-1:0] instr_data;
    logic retire_valid;
    logic [reg_addr_width-1:0] retire_rd;
    logic [xlen-1:0] retire_data;

    logic [xlen-1:0] program_words [max_words];
    int program_length = 0;
    logic [reg_addr_width-1:0] expect_rd [$]; // kept in program order
    logic [xlen-1:0] expect_data [$];
    int expect_group [$];
    int group_left [8]; // writes still owed per test
    int group_errors [8];
    int pass_count = 0;
    int fail_count = 0;

    always #5 clk = ~clk;

    five_stage_cpu dut (
        .clk ( clk ),
        .rst ( rst ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .retire_valid ( retire_valid ),
        .retire_rd ( retire_rd ),
        .retire_data ( retire_data )
    );

    // instruction memory answers in the same cycle
    always_comb begin
        if ({2'b00, instr_addr[xlen-1:2]} < program_length) begin
            instr_data = program_words[instr_addr[$clog2(max_words)+1:2]];
        end else begin
            instr_data = '0; // opcode 0 decodes as a bubble
        end
    end

    task automatic load_testdata();
        int fd;
        string line;
        logic [xlen-1:0] word;
        int group;
        int rd;
        logic [xlen-1:0] value;
        fd = $fopen("sim/five_stage_cpu_testdata.mem", "r");
        if (fd == 0) begin
            $display("cannot open sim/five_stage_cpu_testdata.mem");
            fail_count++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%h %d %d %h", word, group, rd, value) == 4
                    && program_length < max_words) begin
                program_words[program_length] = word;
                program_length++;
                if (rd != 0) begin // rd 0 means the word retires nothing
                    expect_rd.push_back(rd[reg_addr_width-1:0]);
                    expect_data.push_back(value);
                    expect_group.push_back(group % 8);
                    group_left[group % 8]++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] want, input int group);
        assert (got === want) pass_count++;
        else begin
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, want);
            fail_count++;
            group_errors[group]++;
        end
    endtask

    task automatic check_retirement();
        logic [reg_addr_width-1:0] want_rd;
        logic [xlen-1:0] want_data;
        int group;
        if (expect_rd.size() == 0) begin
            $display("unexpected write to x%0d at %0t after the last expected write",
                     retire_rd, $time);
            fail_count++;
            return;
        end
        want_rd = expect_rd.pop_front();
        want_data = expect_data.pop_front();
        group = expect_group.pop_front();
        check_value("retire_rd", xlen'(retire_rd), xlen'(want_rd), group);
        check_value("retire_data", retire_data, want_data, group);
        group_left[group]--;
        if (group_left[group] == 0) begin
            $display("test %0d done, %0d errors", group, group_errors[group]);
        end
    endtask

    always @(posedge clk) begin
        if (rst && retire_valid) begin
            check_retirement();
        end
    end

    initial begin
        int cycle_limit;
        int cycle_count;
        load_testdata();
        cycle_limit = 8 * program_length + 50;
        cycle_count = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        while (expect_rd.size() > 0 && cycle_count < cycle_limit) begin
            @(negedge clk); // retirements are checked on the rising edge
            cycle_count++;
        end
        if (expect_rd.size() > 0) begin
            $display("timeout after %0d cycles, %0d expected register writes never arrived",
                     cycle_count, expect_rd.size());
            fail_count++;
        end
        if (dut.assertions.failures > 0) begin
            $display("%0d bound pipeline assertions did not hold", dut.assertions.failures);
            fail_count += dut.assertions.failures;
        end
        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sim/five_stage_cpu_testdata.mem
// columns: instruction word (hex), test number, expected rd (0 = no write), expected value (hex)
// rows are in program order from address 0, expected writes must retire in this order
00500093 1 1 00000005 // addi x1, x0, 5
FFD00113 1 2 FFFFFFFD // addi x2, x0, -3
0060F193 1 3 00000004 // andi x3, x1, 6
0300E213 1 4 00000035 // ori x4, x1, 0x30
FFF0C293 1 5 FFFFFFFA // xori x5, x1, -1
00112313 1 6 00000001 // slti x6, x2, 1
002083B3 1 7 00000002 // add x7, x1, x2
40208433 1 8 00000008 // sub x8, x1, x2
005274B3 1 9 00000030 // and x9, x4, x5
0030E533 1 10 00000005 // or x10, x1, x3
001245B3 1 11 00000030 // xor x11, x4, x1
00112633 1 12 00000001 // slt x12, x2, x1
0020A6B3 1 13 00000000 // slt x13, x1, x2
00108713 2 14 00000006 // addi x14, x1, 1
00E707B3 2 15 0000000C // add x15, x14, x14
40178833 2 16 00000007 // sub x16, x15, x1
123458B7 3 17 12345000 // lui x17, 0x12345
01102423 3 0 00000000 // sw x17, 8(x0)
00802903 3 18 12345000 // lw x18, 8(x0)
00708013 5 0 00000000 // addi x0, x1, 7
001009B3 5 19 00000005 // add x19, x0, x1
FFFFFFFF 6 0 00000000 // unknown opcode
00900A13 6 20 00000009 // addi x20, x0, 9
00800AEF 4 21 00000060 // jal x21, +8
00100B13 4 0 00000000 // addi x22, x0, 1 is flushed
004A8B93 4 23 00000064 // addi x23, x21, 4
0000006F 4 0 00000000 // jal x0, 0 self loop
